//--- Makefile
SIM      = verilator
FLAGS    = --binary --timing --assert
TOP      = udma_tb
FILELIST = all.f
OBJDIR   = obj_dir
LOG      = sim.log

.PHONY: all compile run clean

all: run

compile:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJDIR)

run: compile
	./$(OBJDIR)/V$(TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "sim failed" $(LOG) || ! grep -q "sim passed" $(LOG); then \
		echo "simulation FAILED, see $(LOG)"; exit 1; \
	fi

clean:
	rm -rf $(OBJDIR) $(LOG)

//--- all.f
hw/udma_pkg.sv
hw/mem_bus_if.sv
hw/udma_chan_if.sv
hw/udma_regs.sv
hw/udma_engine.sv
hw/bus_arbiter.sv
hw/data_ram.sv
hw/udma_top.sv
tb/udma_sva.sv
tb/udma_tb.sv

//--- hw/bus_arbiter.sv
// ------------------------------------------------
// fixed priority ram arbiter, engine over cpu port
// ------------------------------------------------
`timescale 1ns/1ns

module bus_arbiter (
    input  logic                        clk,
    input  logic                        rst,
    mem_bus_if.arbiter                  dma,
    mem_bus_if.arbiter                  cpu,
    output logic                        ram_we,
    output logic [udma_pkg::addr_w-1:0] ram_addr,
    output logic [7:0]                  ram_wdata,
    input  logic [7:0]                  ram_rdata
);

    logic owner_q;                                   // set while the engine owns the ram path
    logic use_dma;

    assign dma.gnt = dma.req;                        // engine always wins
    assign cpu.gnt = cpu.req & ~dma.req;             // cpu waits and keeps req up

    // with nobody requesting the path stays parked on its last owner
    // so the ram inputs only move when a new grant is given
    assign use_dma = dma.req | (~cpu.req & owner_q);

    assign ram_addr  = use_dma ? dma.addr : cpu.addr;
    assign ram_wdata = use_dma ? dma.wdata : cpu.wdata;
    assign ram_we    = (dma.gnt & dma.we) | (cpu.gnt & cpu.we); // never writes without a grant

    assign dma.rdata = ram_rdata;                    // both see the same read port
    assign cpu.rdata = ram_rdata;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            owner_q <= 1'b0;
        end else begin
            owner_q <= use_dma;
        end
    end

endmodule

//--- hw/data_ram.sv
// ------------------------------------------------
// 256 byte shared ram, async read, sync write
// ------------------------------------------------
`timescale 1ns/1ns

module data_ram (
    input  logic                        clk,
    input  logic                        we,
    input  logic [udma_pkg::addr_w-1:0] addr,
    input  logic [7:0]                  wdata,
    output logic [7:0]                  rdata
);
    import udma_pkg::*;

    logic [7:0] mem [2**addr_w];                     // contents undefined until written

    assign rdata = mem[addr];                        // read data follows addr in the same cycle

    always_ff @(posedge clk) begin
        if (we) begin
            mem[addr] <= wdata;                      // lands on the edge that ends the beat
        end
    end

endmodule

//--- hw/mem_bus_if.sv
// ------------------------------------------------
// byte bus port of one ram requester
// ------------------------------------------------
`timescale 1ns/1ns

interface mem_bus_if;
    import udma_pkg::*;

    logic              req;                          // held until gnt is seen
    logic              gnt;                          // high during the beat
    logic              we;                           // write beat when set
    logic [addr_w-1:0] addr;
    logic [7:0]        wdata;
    logic [7:0]        rdata;                        // valid combinationally during the beat

    modport requester (
        output req, we, addr, wdata,
        input  gnt, rdata
    );

    modport arbiter (
        input  req, we, addr, wdata,
        output gnt, rdata
    );

endinterface

//--- hw/udma_chan_if.sv
// ------------------------------------------------
// channel read-out and update path, engine to regs
// ------------------------------------------------
`timescale 1ns/1ns

interface udma_chan_if;
    import udma_pkg::*;

    logic [ch_w-1:0] sel;                            // channel the engine is looking at
    logic            upd;                            // one cycle write-back strobe
    logic [31:0]     new_src;
    logic [31:0]     new_dst;
    logic [15:0]     new_cnt;
    logic [31:0]     src;                            // current values of channel sel
    logic [31:0]     dst;
    logic [15:0]     cnt;
    dma_mode_u       mode;

    modport regs   (input  sel, upd, new_src, new_dst, new_cnt, output src, dst, cnt, mode);
    modport engine (output sel, upd, new_src, new_dst, new_cnt, input  src, dst, cnt, mode);

endinterface

//--- hw/udma_engine.sv
// ------------------------------------------------
// trigger capture, channel pick, byte beat sequencer
// ------------------------------------------------
`timescale 1ns/1ns

module udma_engine (
    input  logic                       clk,
    input  logic                       rst,
    input  logic                       cen,
    input  logic [udma_pkg::num_ch-1:0] trig,
    output logic [udma_pkg::num_ch-1:0] dma_done,
    udma_chan_if.engine                chan,
    mem_bus_if.requester               bus
);
    import udma_pkg::*;

    logic [num_ch-1:0] pending;                      // one captured request per channel
    logic [num_ch-1:0] clr;                          // pending bits retired this cycle
    logic [num_ch-1:0] sel_oh;
    logic [ch_w-1:0]   pick;
    logic [ch_w-1:0]   sel_q;
    logic [2:0]        state;
    logic [1:0]        byte_idx;                     // byte within the current item
    logic [2:0]        step;                         // item size in bytes
    logic              last_byte;
    logic              done_now;
    logic [31:0]       src_q;                        // values sampled in eng_sel
    logic [31:0]       dst_q;
    logic [15:0]       cnt_q;
    dma_mode_u         mode_q;
    logic [7:0]        data_q;                       // byte carried from read to write beat

    always_comb begin
        pick = '0;
        for (int i = num_ch - 1; i >= 0; i--) begin
            if (pending[i]) pick = ch_w'(i);         // lowest index ends up winning
        end
    end

    always_comb begin
        case (mode_q.f.size)
            size_byte: step = 3'd1;
            size_word: step = 3'd2;
            default:   step = 3'd4;                  // long and the unused code
        endcase
    end

    assign last_byte = ({1'b0, byte_idx} == step - 3'd1);
    assign sel_oh    = num_ch'(1) << sel_q;
    assign done_now  = (state == eng_upd) && (chan.new_cnt == 16'd0);
    assign dma_done  = done_now ? sel_oh : '0;       // same cycle as upd
    // a zero count in eng_sel drops the trigger
    assign clr = ((state == eng_upd) || (state == eng_sel && chan.cnt == 16'd0)) ? sel_oh : '0;

    assign chan.sel     = sel_q;
    assign chan.upd     = (state == eng_upd);
    assign chan.new_cnt = cnt_q - 16'd1;

    always_comb begin
        chan.new_src = src_q;
        chan.new_dst = dst_q;
        case (mode_q.f.amode)
            mode_dst_inc: chan.new_dst = dst_q + 32'(step);
            mode_dst_dec: chan.new_dst = dst_q - 32'(step);
            mode_src_inc: chan.new_src = src_q + 32'(step);
            mode_src_dec: chan.new_src = src_q - 32'(step);
            default: ;                               // fixed and count leave both alone
        endcase
    end

    assign bus.req   = (state == eng_rd) || (state == eng_wr);
    assign bus.we    = (state == eng_wr);
    assign bus.addr  = (bus.we ? dst_q[addr_w-1:0] : src_q[addr_w-1:0]) + addr_w'(byte_idx);
    assign bus.wdata = data_q;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            pending  <= '0;
            sel_q    <= '0;
            state    <= eng_idle;
            byte_idx <= '0;
        end else if (cen) begin
            pending <= (pending & ~clr) | trig;      // a new pulse survives its own clear
            case (state)
                eng_idle: if (|pending) begin
                    sel_q <= pick;
                    state <= eng_sel;
                end
                eng_sel: begin
                    byte_idx <= '0;
                    if (chan.cnt == 16'd0) begin
                        state <= eng_idle;
                    end else if (chan.mode.f.amode == mode_count) begin
                        state <= eng_upd;            // counter mode skips the beats
                    end else begin
                        state <= eng_rd;
                    end
                end
                eng_rd: if (bus.gnt) state <= eng_wr;
                eng_wr: if (bus.gnt) begin
                    if (last_byte) begin
                        state <= eng_upd;
                    end else begin
                        byte_idx <= byte_idx + 2'd1;
                        state    <= eng_rd;
                    end
                end
                default: state <= eng_idle;          // eng_upd lasts one cycle
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (cen) begin
            if (state == eng_sel) begin
                src_q  <= chan.src;
                dst_q  <= chan.dst;
                cnt_q  <= chan.cnt;
                mode_q <= chan.mode;
            end
            if (state == eng_rd && bus.gnt) data_q <= bus.rdata;
        end
    end

endmodule

//--- hw/udma_pkg.sv
// ------------------------------------------------
// shared widths, address modes, sizes, engine states
// and the channel mode byte union for the micro-DMA
// ------------------------------------------------
package udma_pkg;

    localparam int num_ch = 4;                       // four independent channels
    localparam int ch_w   = $clog2(num_ch);          // channel index width
    localparam int addr_w = 8;                       // only the low byte of an address reaches the ram

    localparam logic [2:0] mode_dst_inc = 3'd0;      // destination steps up by size
    localparam logic [2:0] mode_dst_dec = 3'd1;      // destination steps down by size
    localparam logic [2:0] mode_src_inc = 3'd2;      // source steps up by size
    localparam logic [2:0] mode_src_dec = 3'd3;      // source steps down by size
    localparam logic [2:0] mode_fixed   = 3'd4;      // both addresses stay put
    localparam logic [2:0] mode_count   = 3'd5;      // no data moves, count only

    localparam logic [1:0] size_byte = 2'd0;         // 1 byte per item
    localparam logic [1:0] size_word = 2'd1;         // 2 bytes per item
    localparam logic [1:0] size_long = 2'd2;         // 4 bytes per item

    localparam logic [2:0] eng_idle = 3'd0;          // waiting for a pending trigger
    localparam logic [2:0] eng_sel  = 3'd1;          // channel registers sampled here
    localparam logic [2:0] eng_rd   = 3'd2;          // read beat from source
    localparam logic [2:0] eng_wr   = 3'd3;          // write beat to destination
    localparam logic [2:0] eng_upd  = 3'd4;          // write back addresses and count

    typedef union packed {
        logic [7:0] raw;                             // cpu view of the mode byte
        struct packed {
            logic [2:0] rsvd;                        // kept but not decoded
            logic [2:0] amode;                       // one of the mode_ values
            logic [1:0] size;                        // one of the size_ values
        } f;
    } dma_mode_u;

endpackage

//--- hw/udma_regs.sv
// ------------------------------------------------
// channel register file, nesting counter, cpu access
// ------------------------------------------------
`timescale 1ns/1ns

module udma_regs (
    input  logic        clk,
    input  logic        rst,
    input  logic        cen,
    input  logic [31:0] regin,
    input  logic [5:0]  regsel,                      // [5:4] group, [3:2] channel, [1:0] lane
    input  logic [2:0]  regwe,                       // long, word, byte strobes
    input  logic        int_inc,
    input  logic        int_dec,
    output logic [31:0] regout,
    udma_chan_if.regs   chan
);
    import udma_pkg::*;

    logic [31:0]     sreg [num_ch];                  // source addresses
    logic [31:0]     dreg [num_ch];                  // destination addresses
    logic [15:0]     dmac [num_ch];                  // item counts
    dma_mode_u       dmam [num_ch];                  // mode bytes
    logic [15:0]     intnest;
    logic [ch_w-1:0] ch;
    logic [31:0]     mc_new;                         // merged {mode, count} word

    // strobes apply in order long, word, byte so a narrower lane overrides
    function automatic logic [31:0] merge_lanes(
        input logic [31:0] old,
        input logic [31:0] din,
        input logic [2:0]  we,
        input logic [1:0]  lane
    );
        logic [31:0] r;
        r = old;
        if (we[2]) r = din;
        if (we[1]) r[lane[1]*16 +: 16] = din[15:0];  // upper or lower half
        if (we[0]) r[lane*8 +: 8] = din[7:0];        // any of the four bytes
        return r;
    endfunction

    assign ch     = regsel[3:2];
    assign mc_new = merge_lanes({8'd0, dmam[ch].raw, dmac[ch]}, regin, regwe, regsel[1:0]);

    assign chan.src  = sreg[chan.sel];               // engine sees its channel without delay
    assign chan.dst  = dreg[chan.sel];
    assign chan.cnt  = dmac[chan.sel];
    assign chan.mode = dmam[chan.sel];

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int i = 0; i < num_ch; i++) begin
                sreg[i] <= '0;
                dreg[i] <= '0;
                dmac[i] <= '0;
                dmam[i] <= '0;
            end
            intnest <= '0;
        end else if (cen) begin
            if (int_dec) begin
                intnest <= intnest - 16'd1;          // decrement has priority over increment
            end else if (int_inc) begin
                intnest <= intnest + 16'd1;
            end
            if (chan.upd) begin
                sreg[chan.sel] <= chan.new_src;      // engine write-back after an item
                dreg[chan.sel] <= chan.new_dst;
                dmac[chan.sel] <= chan.new_cnt;
            end
            if (regwe != 3'b000) begin               // cpu write comes last and wins a clash
                case (regsel[5:4])
                    2'd0: sreg[ch] <= merge_lanes(sreg[ch], regin, regwe, regsel[1:0]);
                    2'd1: dreg[ch] <= merge_lanes(dreg[ch], regin, regwe, regsel[1:0]);
                    2'd2: begin
                        dmam[ch].raw <= mc_new[23:16];
                        dmac[ch]     <= mc_new[15:0];
                    end
                    default: ;                       // nesting counter is read only here
                endcase
            end
        end
    end

    // read data appears one enabled cycle after regsel
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            regout <= '0;
        end else if (cen) begin
            case (regsel[5:4])
                2'd0:    regout <= sreg[ch];
                2'd1:    regout <= dreg[ch];
                2'd2:    regout <= {8'd0, dmam[ch].raw, dmac[ch]};
                default: regout <= {16'd0, intnest};
            endcase
        end
    end

endmodule

//--- hw/udma_top.sv
// ------------------------------------------------
// micro-DMA top, regs, engine, arbiter and ram
// ------------------------------------------------
`timescale 1ns/1ns

module udma_top (
    input  logic                        clk,
    input  logic                        rst,
    input  logic                        cen,
    input  logic [31:0]                 regin,
    input  logic [5:0]                  regsel,
    input  logic [2:0]                  regwe,
    input  logic                        int_inc,
    input  logic                        int_dec,
    output logic [31:0]                 regout,
    input  logic [udma_pkg::num_ch-1:0] trig,
    output logic [udma_pkg::num_ch-1:0] dma_done,
    input  logic                        cpu_req,
    input  logic                        cpu_we,
    input  logic [udma_pkg::addr_w-1:0] cpu_addr,
    input  logic [7:0]                  cpu_wdata,
    output logic [7:0]                  cpu_rdata,
    output logic                        cpu_gnt
);
    import udma_pkg::*;

    udma_chan_if chan_i ();                          // regs to engine channel path
    mem_bus_if   dma_bus_i ();                       // engine side of the arbiter
    mem_bus_if   cpu_bus_i ();                       // cpu side of the arbiter

    logic              ram_we;
    logic [addr_w-1:0] ram_addr;
    logic [7:0]        ram_wdata;
    logic [7:0]        ram_rdata;

    assign cpu_bus_i.req   = cpu_req;
    assign cpu_bus_i.we    = cpu_we;
    assign cpu_bus_i.addr  = cpu_addr;
    assign cpu_bus_i.wdata = cpu_wdata;
    assign cpu_rdata       = cpu_bus_i.rdata;
    assign cpu_gnt         = cpu_bus_i.gnt;

    udma_regs regs_i (.clk, .rst, .cen, .regin, .regsel, .regwe, .int_inc, .int_dec,
                      .regout, .chan(chan_i.regs));

    udma_engine engine_i (.clk, .rst, .cen, .trig, .dma_done, .chan(chan_i.engine),
                          .bus(dma_bus_i.requester));

    bus_arbiter arbiter_i (.clk, .rst, .dma(dma_bus_i.arbiter), .cpu(cpu_bus_i.arbiter),
                           .ram_we, .ram_addr, .ram_wdata, .ram_rdata);

    data_ram ram_i (.clk, .we(ram_we), .addr(ram_addr), .wdata(ram_wdata), .rdata(ram_rdata));

endmodule

//--- tb/udma_sva.sv
// --------------------------------------------------
// bus and engine assertions, bound into the DMA top
// --------------------------------------------------
`timescale 1ns/1ns

module udma_sva (
    input logic                        clk,
    input logic                        rst,
    input logic [udma_pkg::num_ch-1:0] dma_done,
    input logic                        dma_req,
    input logic                        dma_gnt,
    input logic                        cpu_req,
    input logic                        cpu_gnt,
    input logic                        cpu_we,
    input logic [udma_pkg::addr_w-1:0] cpu_addr,
    input logic [7:0]                  cpu_wdata
);

    one_grant: assert property (@(posedge clk) disable iff (rst) !(dma_gnt && cpu_gnt))
        else $error("ram granted to engine and cpu in the same cycle");

    done_onehot: assert property (@(posedge clk) disable iff (rst) $onehot0(dma_done))
        else $error("dma_done has more than one channel set");

    // a waiting requester keeps its request and its beat unchanged
    cpu_hold: assert property (@(posedge clk) disable iff (rst)
        cpu_req && !cpu_gnt |=> cpu_req && $stable({cpu_we, cpu_addr, cpu_wdata}))
        else $error("cpu bus signals moved while waiting for grant");

endmodule

bind udma_top udma_sva udma_sva_i (
    .clk       (clk),
    .rst       (rst),
    .dma_done  (dma_done),
    .dma_req   (dma_bus_i.req),
    .dma_gnt   (dma_bus_i.gnt),
    .cpu_req   (cpu_req),
    .cpu_gnt   (cpu_gnt),
    .cpu_we    (cpu_we),
    .cpu_addr  (cpu_addr),
    .cpu_wdata (cpu_wdata)
);

//--- tb/udma_tb.sv
// --------------------------------------------------
// micro-DMA testbench, step table, checks, timeout
// --------------------------------------------------
`timescale 1ns/1ns

module udma_tb;
    import udma_pkg::*;

    localparam logic [3:0] k_wreg = 4'd0;            // register write
    localparam logic [3:0] k_rreg = 4'd1;            // register read with expected value
    localparam logic [3:0] k_nest = 4'd2;            // int_inc and int_dec pulse, data[1:0] = {dec, inc}
    localparam logic [3:0] k_mwr  = 4'd3;            // cpu ram write
    localparam logic [3:0] k_mrd  = 4'd4;            // cpu ram read with expected byte
    localparam logic [3:0] k_trig = 4'd5;            // trigger, wait for the engine, check done
    localparam logic [3:0] k_fire = 4'd6;            // trigger and move on at once
    localparam logic [3:0] k_done = 4'd7;            // wait for a dma_done pulse

    typedef struct packed {
        logic [3:0]  kind;
        logic [3:0]  test;
        logic [7:0]  sel;                            // regsel, ram address or channel
        logic [2:0]  we;
        logic [31:0] data;
        logic [31:0] exp;
    } step_t;

    logic        clk = 1'b0;
    logic        rst;
    logic        cen;
    logic [31:0] regin;
    logic [5:0]  regsel;
    logic [2:0]  regwe;
    logic        int_inc;
    logic        int_dec;
    logic [31:0] regout;
    logic [3:0]  trig;
    logic [3:0]  dma_done;
    logic        cpu_req;
    logic        cpu_we;
    logic [7:0]  cpu_addr;
    logic [7:0]  cpu_wdata;
    logic [7:0]  cpu_rdata;
    logic        cpu_gnt;

    step_t      steps [$];
    logic [7:0] model [256];                         // expected ram contents
    integer     seed = 59;
    int         cycles = 0;
    int         limit = 0;                           // set once the table is built
    int         checks = 0;
    int         errors = 0;
    int         test_checks = 0;
    int         test_errors = 0;
    int         done_events = 0;
    int         snap = 0;                            // done_events when the last trigger left
    int         cur;
    logic [3:0] last_done = '0;

    udma_top udma_top_i (.clk, .rst, .cen, .regin, .regsel, .regwe, .int_inc, .int_dec,
                         .regout, .trig, .dma_done, .cpu_req, .cpu_we, .cpu_addr, .cpu_wdata,
                         .cpu_rdata, .cpu_gnt);

    always #50 clk = ~clk;

    // done pulses are logged and the run is cut off at the cycle limit
    always @(negedge clk) begin
        cycles <= cycles + 1;
        if (dma_done != '0) begin
            last_done   <= dma_done;
            done_events <= done_events + 1;
        end
        if (limit > 0 && cycles > limit) begin
            $display("timeout: the run did not finish within %0d cycles", limit);
            $display("sim failed");
            $finish;
        end
    end

    task automatic compare(input string what, input logic [31:0] got, input logic [31:0] exp);
        checks++;
        test_checks++;
        if (got !== exp) begin
            errors++;
            test_errors++;
            $display("[ERROR] %0t ns: %s is %h, expected %h", $time, what, got, exp);
        end
    endtask

    function automatic string test_name(input int t);
        case (t)
            1: return "register lanes";
            2: return "nesting counter";
            3: return "byte copy, destination up";
            4: return "long copy, source down";
            5: return "zero count and count mode";
            default: return "cpu access during dma";
        endcase
    endfunction

    function automatic logic [31:0] mode_word(input logic [2:0] amode, input logic [1:0] size,
                                              input logic [15:0] count);
        return {8'd0, 3'b000, amode, size, count};   // {mode, count} as group 2 reads it
    endfunction

    task automatic add_step(input logic [3:0] kind, input int test, input logic [7:0] sel,
                            input logic [2:0] we, input logic [31:0] data,
                            input logic [31:0] exp);
        steps.push_back(step_t'{kind, 4'(test), sel, we, data, exp});
    endtask

    task automatic set_reg(input int test, input logic [5:0] sel, input logic [2:0] we,
                           input logic [31:0] data);
        add_step(k_wreg, test, {2'b00, sel}, we, data, 32'd0);
    endtask

    task automatic expect_reg(input int test, input logic [5:0] sel, input logic [31:0] exp);
        add_step(k_rreg, test, {2'b00, sel}, 3'd0, 32'd0, exp);
    endtask

    task automatic pulse_nest(input int test, input logic [1:0] dec_inc);
        add_step(k_nest, test, 8'd0, 3'd0, {30'd0, dec_inc}, 32'd0);
    endtask

    task automatic trigger(input int test, input int ch, input logic [3:0] done);
        add_step(k_trig, test, 8'(ch), 3'd0, 32'd0, {28'd0, done});
    endtask

    task automatic fill_ram(input int test, input logic [7:0] addr, input int n);
        logic [7:0] a;
        logic [7:0] b;
        for (int i = 0; i < n; i++) begin
            a = addr + 8'(i);
            b = 8'($random(seed));
            model[a] = b;                            // model follows every cpu write
            add_step(k_mwr, test, a, 3'd0, {24'd0, b}, 32'd0);
        end
    endtask

    task automatic expect_ram(input int test, input logic [7:0] addr, input int n);
        logic [7:0] a;
        for (int i = 0; i < n; i++) begin
            a = addr + 8'(i);
            add_step(k_mrd, test, a, 3'd0, 32'd0, {24'd0, model[a]});
        end
    endtask

    // one item moves n bytes, both addresses ascending within the item
    task automatic copy_model(input logic [7:0] src, input logic [7:0] dst, input int n);
        logic [7:0] s;
        logic [7:0] d;
        for (int i = 0; i < n; i++) begin
            s = src + 8'(i);
            d = dst + 8'(i);
            model[d] = model[s];
        end
    endtask

    task automatic build_table();
        set_reg(1, 6'h04, 3'b100, 32'h1122_3344);    // channel 1 source, full word
        set_reg(1, 6'h06, 3'b010, 32'h0000_abcd);    // upper half
        set_reg(1, 6'h05, 3'b001, 32'h0000_005e);    // byte 1
        expect_reg(1, 6'h04, 32'habcd_5e44);
        set_reg(1, 6'h17, 3'b101, 32'h1234_5678);    // long, then byte 3 on top of it
        expect_reg(1, 6'h14, 32'h7834_5678);
        set_reg(1, 6'h24, 3'b100, 32'hffa5_1234);    // top byte of the mode word is not kept
        expect_reg(1, 6'h24, 32'h00a5_1234);
        set_reg(1, 6'h26, 3'b001, 32'h0000_003c);    // mode byte alone
        set_reg(1, 6'h24, 3'b010, 32'h0000_beef);    // count alone
        expect_reg(1, 6'h24, 32'h003c_beef);
        for (int i = 0; i < 3; i++) pulse_nest(2, 2'b01);
        expect_reg(2, 6'h30, 32'd3);
        pulse_nest(2, 2'b11);                        // decrement wins
        expect_reg(2, 6'h30, 32'd2);
        pulse_nest(2, 2'b10);
        expect_reg(2, 6'h30, 32'd1);
        set_reg(3, 6'h00, 3'b100, 32'h0000_0010);
        set_reg(3, 6'h10, 3'b100, 32'h0000_0040);
        set_reg(3, 6'h20, 3'b100, mode_word(mode_dst_inc, size_byte, 16'd3));
        fill_ram(3, 8'h10, 3);
        for (int i = 0; i < 3; i++) begin
            copy_model(8'h10, 8'h40 + 8'(i), 1);     // source does not move in this mode
            trigger(3, 0, (i == 2) ? 4'b0001 : 4'b0000);
        end
        expect_reg(3, 6'h20, mode_word(mode_dst_inc, size_byte, 16'd0));
        expect_reg(3, 6'h10, 32'h0000_0043);
        expect_ram(3, 8'h40, 3);
        set_reg(4, 6'h08, 3'b100, 32'h0000_0080);
        set_reg(4, 6'h18, 3'b100, 32'h0000_00c0);
        set_reg(4, 6'h28, 3'b100, mode_word(mode_src_dec, size_long, 16'd2));
        fill_ram(4, 8'h7c, 8);
        copy_model(8'h80, 8'hc0, 4);
        trigger(4, 2, 4'b0000);
        expect_ram(4, 8'hc0, 4);
        copy_model(8'h7c, 8'hc0, 4);                 // destination stays, source stepped down
        trigger(4, 2, 4'b0100);
        expect_reg(4, 6'h08, 32'h0000_0078);
        expect_ram(4, 8'hc0, 4);
        trigger(5, 3, 4'b0000);                      // count is still zero from reset
        expect_reg(5, 6'h2c, 32'd0);
        expect_reg(5, 6'h1c, 32'd0);
        set_reg(5, 6'h0c, 3'b100, 32'h0000_0020);
        set_reg(5, 6'h1c, 3'b100, 32'h0000_0050);
        set_reg(5, 6'h2c, 3'b100, mode_word(mode_count, size_byte, 16'd2));
        fill_ram(5, 8'h20, 1);
        fill_ram(5, 8'h50, 1);
        trigger(5, 3, 4'b0000);
        expect_reg(5, 6'h2c, mode_word(mode_count, size_byte, 16'd1));
        trigger(5, 3, 4'b1000);
        expect_reg(5, 6'h2c, mode_word(mode_count, size_byte, 16'd0));
        expect_reg(5, 6'h1c, 32'h0000_0050);
        expect_ram(5, 8'h50, 1);
        set_reg(6, 6'h00, 3'b100, 32'h0000_0030);
        set_reg(6, 6'h10, 3'b100, 32'h0000_0060);
        set_reg(6, 6'h20, 3'b100, mode_word(mode_dst_inc, size_long, 16'd1));
        fill_ram(6, 8'h30, 4);
        copy_model(8'h30, 8'h60, 4);
        add_step(k_fire, 6, 8'd0, 3'd0, 32'd0, 32'd0);
        fill_ram(6, 8'h90, 2);                       // these overlap the engine's beats
        expect_ram(6, 8'h90, 2);
        expect_ram(6, 8'h10, 1);
        add_step(k_done, 6, 8'd0, 3'd0, 32'd0, 32'h0000_0001);
        expect_ram(6, 8'h60, 4);
        expect_reg(6, 6'h10, 32'h0000_0064);
    endtask

    task automatic check_done(input logic [31:0] exp);
        compare("done pulse count", 32'(done_events - snap), 32'(exp != 32'd0));
        compare("done channel", (done_events == snap) ? 32'd0 : {28'd0, last_done}, exp);
    endtask

    task automatic run_step(input step_t s);
        @(posedge clk);
        case (s.kind)
            k_wreg, k_rreg: begin
                regsel <= s.sel[5:0];
                regin  <= s.data;
                regwe  <= s.we;
                @(posedge clk);
                regwe <= 3'b000;
                if (s.kind == k_rreg) begin
                    @(negedge clk);                  // regout registered on the edge just passed
                    compare("regout", regout, s.exp);
                end
            end
            k_nest: begin
                int_inc <= s.data[0];
                int_dec <= s.data[1];
                @(posedge clk);
                int_inc <= 1'b0;
                int_dec <= 1'b0;
            end
            k_mwr, k_mrd: begin
                cpu_req   <= 1'b1;
                cpu_we    <= (s.kind == k_mwr);
                cpu_addr  <= s.sel;
                cpu_wdata <= s.data[7:0];
                @(negedge clk);
                while (cpu_gnt !== 1'b1) @(negedge clk);
                if (s.kind == k_mrd) compare("cpu_rdata", {24'd0, cpu_rdata}, s.exp);
                @(posedge clk);                      // beat ends here
                cpu_req <= 1'b0;
                cpu_we  <= 1'b0;
            end
            k_trig, k_fire: begin
                snap = done_events;
                trig <= 4'b0001 << s.sel[1:0];
                @(posedge clk);
                trig <= '0;
                if (s.kind == k_trig) begin
                    @(negedge clk);
                    while (udma_top_i.engine_i.pending != '0 ||
                           udma_top_i.engine_i.state != eng_idle) @(negedge clk);
                    check_done(s.exp);
                end
            end
            default: begin
                @(negedge clk);
                while (done_events == snap) @(negedge clk);
                check_done(s.exp);
            end
        endcase
    endtask

    task automatic report_test(input int t);
        $display("test %0d %s: %0d checks, %0d errors, %s", t, test_name(t), test_checks,
                 test_errors, (test_errors == 0) ? "ok" : "with errors");
    endtask

    initial begin
        rst       = 1'b1;
        cen       = 1'b0;
        regin     = '0;
        regsel    = '0;
        regwe     = '0;
        int_inc   = 1'b0;
        int_dec   = 1'b0;
        trig      = '0;
        cpu_req   = 1'b0;
        cpu_we    = 1'b0;
        cpu_addr  = '0;
        cpu_wdata = '0;
        build_table();
        limit = steps.size() * 40;
        repeat (3) @(posedge clk);
        rst <= 1'b0;
        cen <= 1'b1;
        cur = int'(steps[0].test);
        foreach (steps[i]) begin
            if (int'(steps[i].test) != cur) begin
                report_test(cur);
                cur = int'(steps[i].test);
                test_checks = 0;
                test_errors = 0;
            end
            run_step(steps[i]);
        end
        report_test(cur);
        $display("%0d steps, %0d checks, %0d errors", steps.size(), checks, errors);
        if (errors == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule
